/* design/pcie_stream_pkg.sv */
package pcie_stream_pkg;

  // -------------------------------------------------------------------------
  // stream widths
  // -------------------------------------------------------------------------
  localparam int APP_DATA_W = 64;
  localparam int APP_KEEP_W = APP_DATA_W / 8;
  localparam int TLP_DATA_W = 32;
  localparam int TLP_KEEP_W = TLP_DATA_W / 8;
  localparam int USER_W     = 5;

  // 64-bit application beat, 78 bits
  typedef struct packed {
    logic [APP_DATA_W-1:0] data;
    logic [APP_KEEP_W-1:0] keep;
    logic [USER_W-1:0]     user;
    logic                  last;
  } app_beat_t;

  // 32-bit TLP word, 42 bits
  typedef struct packed {
    logic [TLP_DATA_W-1:0] data;
    logic [TLP_KEEP_W-1:0] keep;
    logic [USER_W-1:0]     user;
    logic                  last;
  } tlp_beat_t;

  // byte order reversal of one word, keep bits follow their bytes
  function automatic tlp_beat_t swap_word(input tlp_beat_t w);
    tlp_beat_t s;
    s = w;
    for (int i = 0; i < TLP_KEEP_W; i++) begin
      s.data[8*i +: 8] = w.data[8*(TLP_KEEP_W-1-i) +: 8];
      s.keep[i]        = w.keep[TLP_KEEP_W-1-i];
    end
    return s;
  endfunction

endpackage

/* design/pcie_link_pkg.sv */
package pcie_link_pkg;

  // -------------------------------------------------------------------------
  // link bring-up
  // -------------------------------------------------------------------------

  // flops in the clock_locked synchronizer
  localparam int LOCK_SYNC_STAGES = 2;

  // down: waiting for lock and link-up
  // settle: link-up seen, counting out the settle period
  // active: both stream paths may take traffic
  typedef enum logic [1:0] {
    LINK_DOWN   = 2'd0,
    LINK_SETTLE = 2'd1,
    LINK_ACTIVE = 2'd2
  } link_state_e;

endpackage

/* design/link_reset_ctrl.sv */
`timescale 1ns/1ps

module link_reset_ctrl
  import pcie_link_pkg::*;
#(
  parameter int LINK_SETTLE_CYCLES = 4
) (
  input  logic PIPE_PCLK_IN,
  input  logic clock_locked,
  input  logic link_up_i,
  output logic link_active_o
);

  localparam int CNT_W = (LINK_SETTLE_CYCLES > 1) ? $clog2(LINK_SETTLE_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LINK_SETTLE_CYCLES - 1);

  logic [LOCK_SYNC_STAGES-1:0] lock_sync_q;
  logic                        lock_ok;
  link_state_e                 state_q;
  link_state_e                 state_d;
  logic [CNT_W-1:0]            settle_cnt_q;

  // lock synchronizer, shifts in ones once the async reset releases
  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      lock_sync_q <= '0;
    end else begin
      lock_sync_q <= {lock_sync_q[LOCK_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign lock_ok = lock_sync_q[LOCK_SYNC_STAGES-1];

  always_comb begin
    state_d = state_q;
    case (state_q)
      LINK_DOWN: begin
        if (lock_ok && link_up_i) begin
          state_d = LINK_SETTLE;
        end
      end
      LINK_SETTLE: begin
        // any dropout restarts the settle period
        if (!link_up_i) begin
          state_d = LINK_DOWN;
        end else if (settle_cnt_q == CNT_LAST) begin
          state_d = LINK_ACTIVE;
        end
      end
      LINK_ACTIVE: begin
        if (!link_up_i) begin
          state_d = LINK_DOWN;
        end
      end
      default: state_d = LINK_DOWN;
    endcase
  end

  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      state_q       <= LINK_DOWN;
      settle_cnt_q  <= '0;
      link_active_o <= 1'b0;
    end else begin
      state_q       <= state_d;
      settle_cnt_q  <= (state_q == LINK_SETTLE) ? settle_cnt_q + 1'b1 : '0;
      // drops on the first cycle link-up is seen low
      link_active_o <= (state_q == LINK_ACTIVE) && link_up_i;
    end
  end

endmodule

/* design/tx_lane_downsizer.sv */
`timescale 1ns/1ps

module tx_lane_downsizer
  import pcie_stream_pkg::*;
(
  input  logic      PIPE_PCLK_IN,
  input  logic      clock_locked,
  input  logic      path_en_i,
  input  app_beat_t app_tx_i,
  input  logic      app_tx_valid_i,
  output logic      app_tx_ready_o,
  output tlp_beat_t tlp_tx_o,
  output logic      tlp_tx_valid_o,
  input  logic      tlp_tx_ready_i
);

  // beat register, hi_sel_q set once its low half has gone out
  app_beat_t beat_q;
  logic      beat_valid_q;
  logic      hi_sel_q;

  // output word register
  tlp_beat_t word_q;
  logic      word_valid_q;

  logic      out_free;
  logic      beat_hi;
  logic      beat_done;
  logic      in_hi;
  logic      app_acc;
  logic      bypass;
  tlp_beat_t beat_word;
  tlp_beat_t in_word;

  // one half of a beat as a swapped TLP word
  function automatic tlp_beat_t split_word(input app_beat_t b, input logic hi);
    tlp_beat_t w;
    logic      has_hi;
    has_hi = |b.keep[APP_KEEP_W-1:TLP_KEEP_W];
    if (hi) begin
      w.data = b.data[APP_DATA_W-1:TLP_DATA_W];
      w.keep = b.keep[APP_KEEP_W-1:TLP_KEEP_W];
      w.last = b.last;
    end else begin
      w.data = b.data[TLP_DATA_W-1:0];
      w.keep = b.keep[TLP_KEEP_W-1:0];
      // short tail ends on the low word
      w.last = b.last && !has_hi;
    end
    w.user = b.user;
    return swap_word(w);
  endfunction

  assign out_free  = !word_valid_q || tlp_tx_ready_i;
  assign beat_hi   = |beat_q.keep[APP_KEEP_W-1:TLP_KEEP_W];
  assign beat_done = beat_valid_q && out_free && (hi_sel_q || !beat_hi);
  assign in_hi     = |app_tx_i.keep[APP_KEEP_W-1:TLP_KEEP_W];

  assign app_tx_ready_o = path_en_i && (!beat_valid_q || beat_done);
  assign app_acc        = app_tx_valid_i && app_tx_ready_o;
  // low half goes straight to the word register when nothing is queued
  assign bypass         = app_acc && out_free && !beat_valid_q;

  assign beat_word = split_word(beat_q, hi_sel_q);
  assign in_word   = split_word(app_tx_i, 1'b0);

  // -------------------------------------------------------------------------
  // control
  // -------------------------------------------------------------------------
  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      beat_valid_q <= 1'b0;
      hi_sel_q     <= 1'b0;
      word_valid_q <= 1'b0;
    end else begin
      if (out_free) begin
        word_valid_q <= beat_valid_q || app_acc;
      end
      if (app_acc) begin
        beat_valid_q <= bypass ? in_hi : 1'b1;
        hi_sel_q     <= bypass;
      end else if (beat_valid_q && out_free) begin
        if (beat_done) begin
          beat_valid_q <= 1'b0;
        end else begin
          hi_sel_q <= 1'b1;
        end
      end
    end
  end

  // payload, the queued beat has priority over a new one
  always_ff @(posedge PIPE_PCLK_IN) begin
    if (out_free) begin
      if (beat_valid_q) begin
        word_q <= beat_word;
      end else if (app_acc) begin
        word_q <= in_word;
      end
    end
    if (app_acc) begin
      beat_q <= app_tx_i;
    end
  end

  assign tlp_tx_o       = word_q;
  assign tlp_tx_valid_o = word_valid_q;

endmodule

/* design/rx_lane_upsizer.sv */
`timescale 1ns/1ps

module rx_lane_upsizer
  import pcie_stream_pkg::*;
(
  input  logic      PIPE_PCLK_IN,
  input  logic      clock_locked,
  input  logic      path_en_i,
  input  tlp_beat_t tlp_rx_i,
  input  logic      tlp_rx_valid_i,
  output logic      tlp_rx_ready_o,
  output app_beat_t app_rx_o,
  output logic      app_rx_valid_o,
  input  logic      app_rx_ready_i
);

  localparam tlp_beat_t NO_WORD = '0;

  // low holding word, pairs with the next incoming word
  tlp_beat_t lo_q;
  logic      lo_valid_q;

  // output beat register
  app_beat_t out_q;
  logic      out_valid_q;

  tlp_beat_t in_word;
  logic      out_free;
  logic      lo_closed;
  logic      word_acc;
  logic      pair_done;
  logic      single_in;
  logic      out_load;
  app_beat_t beat_d;

  // first word is the low half and supplies user
  function automatic app_beat_t pack_beat(input tlp_beat_t lo, input tlp_beat_t hi);
    app_beat_t b;
    b.data = {hi.data, lo.data};
    b.keep = {hi.keep, lo.keep};
    b.user = lo.user;
    b.last = lo.last || hi.last;
    return b;
  endfunction

  assign in_word   = swap_word(tlp_rx_i);
  assign out_free  = !out_valid_q || app_rx_ready_i;
  // a held last word closes its beat alone
  assign lo_closed = lo_valid_q && lo_q.last;

  assign tlp_rx_ready_o = path_en_i && (!lo_valid_q || (out_free && !lo_q.last));
  assign word_acc       = tlp_rx_valid_i && tlp_rx_ready_o;
  assign pair_done      = word_acc && lo_valid_q;
  assign single_in      = word_acc && !lo_valid_q && in_word.last && out_free;
  assign out_load       = out_free && (lo_closed || pair_done || single_in);

  always_comb begin
    if (lo_closed) begin
      beat_d = pack_beat(lo_q, NO_WORD);
    end else if (pair_done) begin
      beat_d = pack_beat(lo_q, in_word);
    end else begin
      beat_d = pack_beat(in_word, NO_WORD);
    end
  end

  // -------------------------------------------------------------------------
  // control
  // -------------------------------------------------------------------------
  always_ff @(posedge PIPE_PCLK_IN or negedge clock_locked) begin
    if (!clock_locked) begin
      lo_valid_q  <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (out_free) begin
        out_valid_q <= out_load;
      end
      if ((lo_closed && out_free) || pair_done) begin
        lo_valid_q <= 1'b0;
      end else if (word_acc && !single_in) begin
        lo_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge PIPE_PCLK_IN) begin
    if (out_load) begin
      out_q <= beat_d;
    end
    if (word_acc && !lo_valid_q) begin
      lo_q <= in_word;
    end
  end

  assign app_rx_o       = out_q;
  assign app_rx_valid_o = out_valid_q;

endmodule

/* design/pcie_app_bridge.sv */
`timescale 1ns/1ps

module pcie_app_bridge
  import pcie_stream_pkg::*;
#(
  parameter int LINK_SETTLE_CYCLES = 4
) (
  input  logic      PIPE_PCLK_IN,
  input  logic      clock_locked,
  input  logic      link_up_i,
  output logic      link_active_o,
  // application transmit stream
  input  app_beat_t app_tx_i,
  input  logic      app_tx_valid_i,
  output logic      app_tx_ready_o,
  // TLP transmit stream
  output tlp_beat_t tlp_tx_o,
  output logic      tlp_tx_valid_o,
  input  logic      tlp_tx_ready_i,
  // TLP receive stream
  input  tlp_beat_t tlp_rx_i,
  input  logic      tlp_rx_valid_i,
  output logic      tlp_rx_ready_o,
  // application receive stream
  output app_beat_t app_rx_o,
  output logic      app_rx_valid_o,
  input  logic      app_rx_ready_i
);

  logic path_en;

  // -------------------------------------------------------------------------
  // lock and link-up qualification
  // -------------------------------------------------------------------------
  link_reset_ctrl #(
    .LINK_SETTLE_CYCLES(LINK_SETTLE_CYCLES)
  ) u_link_reset_ctrl (
    .PIPE_PCLK_IN (PIPE_PCLK_IN),
    .clock_locked (clock_locked),
    .link_up_i    (link_up_i),
    .link_active_o(path_en)
  );

  assign link_active_o = path_en;

  // -------------------------------------------------------------------------
  // stream paths
  // -------------------------------------------------------------------------
  tx_lane_downsizer u_tx_lane_downsizer (
    .PIPE_PCLK_IN  (PIPE_PCLK_IN),
    .clock_locked  (clock_locked),
    .path_en_i     (path_en),
    .app_tx_i      (app_tx_i),
    .app_tx_valid_i(app_tx_valid_i),
    .app_tx_ready_o(app_tx_ready_o),
    .tlp_tx_o      (tlp_tx_o),
    .tlp_tx_valid_o(tlp_tx_valid_o),
    .tlp_tx_ready_i(tlp_tx_ready_i)
  );

  rx_lane_upsizer u_rx_lane_upsizer (
    .PIPE_PCLK_IN  (PIPE_PCLK_IN),
    .clock_locked  (clock_locked),
    .path_en_i     (path_en),
    .tlp_rx_i      (tlp_rx_i),
    .tlp_rx_valid_i(tlp_rx_valid_i),
    .tlp_rx_ready_o(tlp_rx_ready_o),
    .app_rx_o      (app_rx_o),
    .app_rx_valid_o(app_rx_valid_o),
    .app_rx_ready_i(app_rx_ready_i)
  );

endmodule

/* verif/tb_pcie_app_bridge.sv */
`timescale 1ns/1ps

module tb_pcie_app_bridge
  import pcie_stream_pkg::*;
  import pcie_link_pkg::*;
();

  localparam int SETTLE       = 4;
  localparam int TX_PKTS      = 24;
  localparam int RX_PKTS      = 24;
  localparam int MAX_TX_BEATS = 4;
  localparam int MAX_RX_WORDS = 7;
  localparam int DROP_BEATS   = 4;
  localparam int TOTAL_BEATS  = TX_PKTS * MAX_TX_BEATS + RX_PKTS * MAX_RX_WORDS + DROP_BEATS;
  localparam int CYCLE_LIMIT  = 20 * TOTAL_BEATS + 200;

  logic      PIPE_PCLK_IN;
  logic      clock_locked;
  logic      link_up;
  logic      link_active;
  app_beat_t app_tx;
  logic      app_tx_valid;
  logic      app_tx_ready;
  tlp_beat_t tlp_tx;
  logic      tlp_tx_valid;
  logic      tlp_tx_ready;
  tlp_beat_t tlp_rx;
  logic      tlp_rx_valid;
  logic      tlp_rx_ready;
  app_beat_t app_rx;
  logic      app_rx_valid;
  logic      app_rx_ready;

  // reference queues and the held first word of an open rx pair
  tlp_beat_t tx_exp[$];
  app_beat_t rx_exp[$];
  tlp_beat_t rx_lo;
  logic      rx_lo_held;
  tlp_beat_t tx_head;
  logic      tx_head_vld;
  app_beat_t rx_head;
  logic      rx_head_vld;

  logic [31:0] tx_rng;
  logic [31:0] rx_rng;
  logic [31:0] stall_rng;
  logic [1:0]  ready_mode;
  logic        exp_active;
  int          cycle_cnt;
  int          tx_errors;
  int          rx_errors;
  int          link_errors;

  pcie_app_bridge #(
    .LINK_SETTLE_CYCLES(SETTLE)
  ) dut_i (
    .PIPE_PCLK_IN  (PIPE_PCLK_IN),
    .clock_locked  (clock_locked),
    .link_up_i     (link_up),
    .link_active_o (link_active),
    .app_tx_i      (app_tx),
    .app_tx_valid_i(app_tx_valid),
    .app_tx_ready_o(app_tx_ready),
    .tlp_tx_o      (tlp_tx),
    .tlp_tx_valid_o(tlp_tx_valid),
    .tlp_tx_ready_i(tlp_tx_ready),
    .tlp_rx_i      (tlp_rx),
    .tlp_rx_valid_i(tlp_rx_valid),
    .tlp_rx_ready_o(tlp_rx_ready),
    .app_rx_o      (app_rx),
    .app_rx_valid_o(app_rx_valid),
    .app_rx_ready_i(app_rx_ready)
  );

  initial begin
    PIPE_PCLK_IN = 1'b0;
    forever #5 PIPE_PCLK_IN = ~PIPE_PCLK_IN;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // byte 0 takes byte 3, byte 1 takes byte 2
  function automatic logic [31:0] swap_bytes(input logic [31:0] d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

  function automatic logic [3:0] swap_keep(input logic [3:0] k);
    return {k[0], k[1], k[2], k[3]};
  endfunction

  function automatic logic [7:0] tail_keep(input int n_bytes);
    logic [7:0] k;
    for (int i = 0; i < 8; i++) begin
      k[i] = (i < n_bytes);
    end
    return k;
  endfunction

  // -------------------------------------------------------------------------
  // reference models
  // -------------------------------------------------------------------------
  function automatic void push_tx_words(input app_beat_t b);
    tlp_beat_t w;
    logic      has_hi;
    has_hi = (b.keep[7:4] != 4'h0);
    w.data = swap_bytes(b.data[31:0]);
    w.keep = swap_keep(b.keep[3:0]);
    w.user = b.user;
    w.last = b.last && !has_hi;
    tx_exp.push_back(w);
    if (has_hi) begin
      w.data = swap_bytes(b.data[63:32]);
      w.keep = swap_keep(b.keep[7:4]);
      w.last = b.last;
      tx_exp.push_back(w);
    end
  endfunction

  function automatic void collect_rx_word(input tlp_beat_t raw);
    tlp_beat_t w;
    app_beat_t b;
    w      = raw;
    w.data = swap_bytes(raw.data);
    w.keep = swap_keep(raw.keep);
    if (rx_lo_held) begin
      b.data     = {w.data, rx_lo.data};
      b.keep     = {w.keep, rx_lo.keep};
      b.user     = rx_lo.user;
      b.last     = w.last;
      rx_lo_held = 1'b0;
      rx_exp.push_back(b);
    end else if (w.last) begin
      // odd tail closes with an empty upper half
      b.data = {32'h0, w.data};
      b.keep = {4'h0, w.keep};
      b.user = w.user;
      b.last = 1'b1;
      rx_exp.push_back(b);
    end else begin
      rx_lo      = w;
      rx_lo_held = 1'b1;
    end
  endfunction

  always @(posedge PIPE_PCLK_IN) begin
    if (tlp_tx_valid && tlp_tx_ready && tx_exp.size() > 0) begin
      tx_exp.delete(0);
    end
    if (app_rx_valid && app_rx_ready && rx_exp.size() > 0) begin
      rx_exp.delete(0);
    end
    if (app_tx_valid && app_tx_ready) begin
      push_tx_words(app_tx);
    end
    if (tlp_rx_valid && tlp_rx_ready) begin
      collect_rx_word(tlp_rx);
    end
    tx_head_vld <= (tx_exp.size() > 0);
    tx_head     <= (tx_exp.size() > 0) ? tx_exp[0] : '0;
    rx_head_vld <= (rx_exp.size() > 0);
    rx_head     <= (rx_exp.size() > 0) ? rx_exp[0] : '0;
  end

  tx_word_expected: assert property (@(posedge PIPE_PCLK_IN) disable iff (!clock_locked)
      (tlp_tx_valid && tlp_tx_ready) |-> tx_head_vld)
    else begin
      tx_errors++;
      $display("tlp_tx_o delivered a word that no application beat produced");
    end

  tx_word_value: assert property (@(posedge PIPE_PCLK_IN) disable iff (!clock_locked)
      (tlp_tx_valid && tlp_tx_ready && tx_head_vld) |-> (tlp_tx == tx_head))
    else begin
      tx_errors++;
      $display("FAILED tlp_tx_o expected %h actual %h", $sampled(tx_head), $sampled(tlp_tx));
    end

  rx_beat_expected: assert property (@(posedge PIPE_PCLK_IN) disable iff (!clock_locked)
      (app_rx_valid && app_rx_ready) |-> rx_head_vld)
    else begin
      rx_errors++;
      $display("app_rx_o delivered a beat that no TLP word produced");
    end

  rx_beat_value: assert property (@(posedge PIPE_PCLK_IN) disable iff (!clock_locked)
      (app_rx_valid && app_rx_ready && rx_head_vld) |-> (app_rx == rx_head))
    else begin
      rx_errors++;
      $display("FAILED app_rx_o expected %h actual %h", $sampled(rx_head), $sampled(app_rx));
    end

  // 0 always ready, 1 random stalls, 2 held off
  always @(posedge PIPE_PCLK_IN) begin
    if (ready_mode == 2'd1) begin
      stall_rng = xorshift32(stall_rng);
      tlp_tx_ready <= (stall_rng[1:0] != 2'b00);
      app_rx_ready <= (stall_rng[3:2] != 2'b00);
    end else begin
      tlp_tx_ready <= (ready_mode == 2'd0);
      app_rx_ready <= (ready_mode == 2'd0);
    end
  end

  always @(posedge PIPE_PCLK_IN) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, streams did not drain", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // -------------------------------------------------------------------------
  // stimulus
  // -------------------------------------------------------------------------
  task automatic check_idle();
    assert (!link_active && !tlp_tx_valid && !app_rx_valid && !app_tx_ready && !tlp_rx_ready)
      else begin
        link_errors++;
        $display("outputs active while reset or lock synchronization is pending");
      end
  endtask

  task automatic drive_app_beat(input app_beat_t b);
    app_tx       <= b;
    app_tx_valid <= 1'b1;
    @(posedge PIPE_PCLK_IN);
    while (!app_tx_ready) begin
      @(posedge PIPE_PCLK_IN);
    end
    app_tx_valid <= 1'b0;
  endtask

  task automatic drive_tlp_word(input tlp_beat_t w);
    tlp_rx       <= w;
    tlp_rx_valid <= 1'b1;
    @(posedge PIPE_PCLK_IN);
    while (!tlp_rx_ready) begin
      @(posedge PIPE_PCLK_IN);
    end
    tlp_rx_valid <= 1'b0;
  endtask

  task automatic send_app_packet(input int n_beats, input int tail_bytes);
    app_beat_t b;
    tx_rng = xorshift32(tx_rng);
    b.user = tx_rng[4:0];
    for (int i = 0; i < n_beats; i++) begin
      tx_rng        = xorshift32(tx_rng);
      b.data[31:0]  = tx_rng;
      tx_rng        = xorshift32(tx_rng);
      b.data[63:32] = tx_rng;
      b.last        = (i == n_beats - 1);
      b.keep        = b.last ? tail_keep(tail_bytes) : 8'hFF;
      drive_app_beat(b);
      if (tx_rng[7]) begin
        @(posedge PIPE_PCLK_IN);
      end
    end
  endtask

  task automatic send_tlp_packet(input int n_words);
    tlp_beat_t w;
    for (int i = 0; i < n_words; i++) begin
      rx_rng = xorshift32(rx_rng);
      w.data = rx_rng;
      rx_rng = xorshift32(rx_rng);
      w.user = rx_rng[8:4];
      w.last = (i == n_words - 1);
      w.keep = w.last ? (rx_rng[3:0] | 4'h8) : 4'hF;
      drive_tlp_word(w);
    end
  endtask

  task automatic send_random_app_packet();
    tx_rng = xorshift32(tx_rng);
    send_app_packet(int'(tx_rng[1:0]) + 1, int'(tx_rng[4:2]) + 1);
  endtask

  task automatic send_random_tlp_packet();
    rx_rng = xorshift32(rx_rng);
    send_tlp_packet(int'(rx_rng[7:0] % 8'd7) + 1);
  endtask

  // looks at the queues between edges, then realigns to a rising edge
  task automatic wait_drain();
    @(negedge PIPE_PCLK_IN);
    while (tx_exp.size() != 0 || rx_exp.size() != 0 || rx_lo_held) begin
      @(negedge PIPE_PCLK_IN);
    end
    @(posedge PIPE_PCLK_IN);
  endtask

  initial begin
    clock_locked = 1'b0;
    link_up      = 1'b0;
    app_tx       = '0;
    app_tx_valid = 1'b0;
    tlp_tx_ready = 1'b0;
    tlp_rx       = '0;
    tlp_rx_valid = 1'b0;
    app_rx_ready = 1'b0;
    rx_lo        = '0;
    rx_lo_held   = 1'b0;
    tx_head      = '0;
    tx_head_vld  = 1'b0;
    rx_head      = '0;
    rx_head_vld  = 1'b0;
    ready_mode   = 2'd0;
    cycle_cnt    = 0;
    tx_errors    = 0;
    rx_errors    = 0;
    link_errors  = 0;
    tx_rng       = 32'd2368;
    rx_rng       = xorshift32(tx_rng);
    stall_rng    = xorshift32(rx_rng);

    repeat (8) begin
      @(posedge PIPE_PCLK_IN);
      check_idle();
    end
    clock_locked <= 1'b1;
    repeat (LOCK_SYNC_STAGES) begin
      @(posedge PIPE_PCLK_IN);
      check_idle();
    end

    // rise lands on the edge 2 + SETTLE after link-up is driven
    link_up <= 1'b1;
    for (int k = 1; k <= SETTLE + 3; k++) begin
      @(posedge PIPE_PCLK_IN);
      exp_active = (k == SETTLE + 3);
      assert (link_active == exp_active)
        else begin
          link_errors++;
          $display("FAILED link_active_o expected %h actual %h", exp_active, link_active);
        end
    end

    // directed packets, short tails and odd word counts
    fork
      begin
        send_app_packet(2, 8);
        send_app_packet(1, 3);
        send_app_packet(3, 4);
        send_app_packet(2, 6);
      end
      begin
        send_tlp_packet(2);
        send_tlp_packet(3);
        send_tlp_packet(1);
        send_tlp_packet(4);
      end
    join
    ready_mode <= 2'd1;
    fork
      repeat (TX_PKTS - 4) send_random_app_packet();
      repeat (RX_PKTS - 4) send_random_tlp_packet();
    join
    ready_mode <= 2'd0;
    wait_drain();

    // -----------------------------------------------------------------------
    // link drop with data held inside both paths
    // -----------------------------------------------------------------------
    ready_mode <= 2'd2;
    repeat (2) @(posedge PIPE_PCLK_IN);
    drive_app_beat('{data: 64'h0123_4567_89ab_cdef, keep: 8'hFF, user: 5'h11, last: 1'b1});
    drive_tlp_word('{data: 32'h1122_3344, keep: 4'hF, user: 5'h05, last: 1'b0});
    drive_tlp_word('{data: 32'h5566_7788, keep: 4'hC, user: 5'h06, last: 1'b1});
    link_up <= 1'b0;
    repeat (2) @(posedge PIPE_PCLK_IN);
    assert (!link_active)
      else begin
        link_errors++;
        $display("FAILED link_active_o expected %h actual %h", 1'b0, link_active);
      end
    app_tx       <= '{data: 64'hdead_beef_0bad_f00d, keep: 8'hFF, user: 5'h1f, last: 1'b1};
    app_tx_valid <= 1'b1;
    tlp_rx       <= '{data: 32'hcafe_d00d, keep: 4'hF, user: 5'h0a, last: 1'b1};
    tlp_rx_valid <= 1'b1;
    ready_mode   <= 2'd0;
    repeat (16) begin
      @(posedge PIPE_PCLK_IN);
      assert (!app_tx_ready && !tlp_rx_ready)
        else begin
          link_errors++;
          $display("an input stream was ready after the link went down");
        end
    end
    app_tx_valid <= 1'b0;
    tlp_rx_valid <= 1'b0;
    wait_drain();

    $display("errors: tx %0d, rx %0d, link %0d", tx_errors, rx_errors, link_errors);
    if (tx_errors + rx_errors + link_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* pcie_app_bridge.f */
design/pcie_stream_pkg.sv
design/pcie_link_pkg.sv
design/link_reset_ctrl.sv
design/tx_lane_downsizer.sv
design/rx_lane_upsizer.sv
design/pcie_app_bridge.sv
verif/tb_pcie_app_bridge.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_pcie_app_bridge
FILELIST  ?= pcie_app_bridge.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
